// File: cpu8_exec.f
+incdir+include
rtl/arch_defs_pkg.sv
rtl/pipe_pkg.sv
rtl/instr_decode.sv
rtl/pipe_stage.sv
rtl/alu_execute.sv
rtl/status_logic_unit.sv
rtl/writeback_unit.sv
rtl/cpu8_exec_top.sv
test/tb_cpu8_exec.sv

// File: include/cpu8_exec_cfg.svh
`ifndef CPU8_EXEC_CFG_SVH
`define CPU8_EXEC_CFG_SVH

// Datapath width of registers, memory and operands
`define CPU8_DATA_WIDTH 8

// Number of bytes in the data memory
`define CPU8_MEM_DEPTH 256

// Stack starts at the top of memory and grows downward
`define CPU8_SP_RESET 8'hFF

// Width of the ALU operation field
`define CPU8_ALU_OP_W 4

`endif

// File: rtl/alu_execute.sv
`include "cpu8_exec_cfg.svh"

module alu_execute
    import arch_defs_pkg::*;
    import pipe_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  decoded_t     dec,
    input  logic         dec_valid,
    input  logic         fire,
    input  exec_result_t fwd,
    input  logic         fwd_valid,
    input  arch_state_t  arch_state,
    output exec_result_t res
);

    localparam int DW = `CPU8_DATA_WIDTH;

    logic [DW-1:0] mem [`CPU8_MEM_DEPTH];
    logic [DW-1:0] sp_q;
    logic [DW-1:0] sp_inc;
    logic [DW-1:0] op_a;
    logic [DW-1:0] op_b;
    logic [DW-1:0] pass_data;
    logic [DW:0]   alu_wide;

    // Operands from committed state, older in-flight result wins
    always_comb begin
        op_a = arch_state.a;
        op_b = arch_state.b;
        if (fwd_valid && fwd.reg_wr && fwd.dest == REG_A) begin
            op_a = fwd.value;
        end
        if (fwd_valid && fwd.reg_wr && fwd.dest == REG_B) begin
            op_b = fwd.value;
        end
    end

    // Pull reads the slot above the current SP
    assign sp_inc = sp_q + 1'b1;

    // Pass-through data for loads, stores show A as their value
    always_comb begin
        if (dec.mem_rd) begin
            pass_data = mem[dec.operand];
        end else if (dec.pull) begin
            pass_data = mem[sp_inc];
        end else if (dec.mem_wr || dec.push) begin
            pass_data = op_a;
        end else begin
            pass_data = dec.operand;
        end
    end

    // ALU with one extra bit for carry or borrow
    always_comb begin
        case (dec.alu_op)
            ALU_ADD: alu_wide = {1'b0, op_a} + {1'b0, op_b};
            ALU_SUB: alu_wide = {1'b0, op_a} - {1'b0, op_b};
            ALU_AND: alu_wide = {1'b0, op_a & op_b};
            ALU_OR:  alu_wide = {1'b0, op_a | op_b};
            ALU_XOR: alu_wide = {1'b0, op_a ^ op_b};
            ALU_INR: alu_wide = {1'b0, op_a} + 1'b1;
            ALU_DCR: alu_wide = {1'b0, op_a} - 1'b1;
            default: alu_wide = {1'b0, pass_data};
        endcase
    end

    always_comb begin
        res              = '0;
        res.opcode       = dec.opcode;
        res.alu_op       = dec.alu_op;
        res.dest         = dec.dest;
        res.reg_wr       = dec.reg_wr;
        res.value        = alu_wide[DW-1:0];
        res.flag_en      = dec.flag_en;
        res.load_sets_zn = dec.load_sets_zn;
        // Raw flags, final choice happens at writeback
        res.alu_zero     = (alu_wide[DW-1:0] == '0);
        res.alu_negative = alu_wide[DW-1];
        res.alu_carry    = alu_wide[DW];
        res.illegal      = dec.illegal;
    end

    // Memory commits as the entry moves on to slot_exe
    always_ff @(posedge clk) begin
        if (fire && dec_valid) begin
            if (dec.mem_wr) begin
                mem[dec.operand] <= op_a;
            end
            if (dec.push) begin
                mem[sp_q] <= op_a;
            end
        end
    end

    // Stack pointer, post-decrement on push and pre-increment on pull
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sp_q <= `CPU8_SP_RESET;
        end else if (fire && dec_valid) begin
            if (dec.push) begin
                sp_q <= sp_q - 1'b1;
            end else if (dec.pull) begin
                sp_q <= sp_inc;
            end
        end
    end

    // Decode never asks for both stack directions at once
    a_push_pull_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        dec_valid |-> !(dec.push && dec.pull)
    );

endmodule

// File: rtl/arch_defs_pkg.sv
`include "cpu8_exec_cfg.svh"

package arch_defs_pkg;

    // Instruction opcodes, grouped by function in the upper nibble
    typedef enum logic [7:0] {
        NOP    = 8'h00,
        // Immediate loads
        LDI_A  = 8'h01,
        LDI_B  = 8'h02,
        LDI_C  = 8'h03,
        // Direct memory access of A
        LDA    = 8'h10,
        STA    = 8'h11,
        // Stack access of A
        PHA    = 8'h20,
        PLA    = 8'h21,
        // Two-operand ALU, A op B into A
        ADD    = 8'h30,
        SUB    = 8'h31,
        AND_OP = 8'h32,
        OR_OP  = 8'h33,
        XOR_OP = 8'h34,
        // Single-operand ALU on A
        INR    = 8'h40,
        DCR    = 8'h41
    } opcode_t;

    // ALU function select
    typedef enum logic [`CPU8_ALU_OP_W-1:0] {
        ALU_PASS = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_AND  = 4'd3,
        ALU_OR   = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_INR  = 4'd6,
        ALU_DCR  = 4'd7
    } alu_op_t;

    // Register file index
    typedef enum logic [1:0] {
        REG_A = 2'd0,
        REG_B = 2'd1,
        REG_C = 2'd2
    } reg_idx_t;

    // Bit positions in the status register
    localparam int STATUS_CPU_ZERO     = 0;
    localparam int STATUS_CPU_NEGATIVE = 1;
    localparam int STATUS_CPU_CARRY    = 2;

endpackage

// File: rtl/cpu8_exec_top.sv
module cpu8_exec_top
    import pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    instr_valid,
    output logic    instr_ready,
    input  instr_t  instr,
    output logic    retire_valid,
    input  logic    retire_ready,
    output retire_t retire
);

    decoded_t     dec_in;
    decoded_t     dec_q;
    logic         dec_q_valid;
    exec_result_t exe_in;
    exec_result_t exe_q;
    logic         exe_q_valid;
    logic         exe_in_ready;
    logic         exe_out_ready;
    arch_state_t  arch_state;

    instr_decode u_decode (
        .instr (instr),
        .dec   (dec_in)
    );

    // Decoded instruction slot
    pipe_stage #(.payload_t(decoded_t)) slot_dec (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (instr_valid),
        .in_ready  (instr_ready),
        .in_data   (dec_in),
        .out_valid (dec_q_valid),
        .out_ready (exe_in_ready),
        .out_data  (dec_q)
    );

    // Fire marks the hand-off into slot_exe, memory commits here
    alu_execute u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec        (dec_q),
        .dec_valid  (dec_q_valid),
        .fire       (dec_q_valid && exe_in_ready),
        .fwd        (exe_q),
        .fwd_valid  (exe_q_valid),
        .arch_state (arch_state),
        .res        (exe_in)
    );

    // Executed result slot, also the forwarding source
    pipe_stage #(.payload_t(exec_result_t)) slot_exe (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (dec_q_valid),
        .in_ready  (exe_in_ready),
        .in_data   (exe_in),
        .out_valid (exe_q_valid),
        .out_ready (exe_out_ready),
        .out_data  (exe_q)
    );

    writeback_unit u_writeback (
        .clk          (clk),
        .rst_n        (rst_n),
        .res          (exe_q),
        .res_valid    (exe_q_valid),
        .res_ready    (exe_out_ready),
        .arch_state   (arch_state),
        .retire       (retire),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready)
    );

endmodule

// File: rtl/instr_decode.sv
`include "cpu8_exec_cfg.svh"

module instr_decode
    import arch_defs_pkg::*;
    import pipe_pkg::*;
(
    input  instr_t   instr,
    output decoded_t dec
);

    always_comb begin
        // Safe defaults: no writes, no flag update
        dec              = '0;
        dec.opcode       = instr.opcode;
        dec.operand      = instr.operand;
        dec.alu_op       = ALU_PASS;
        dec.dest         = REG_A;

        case (instr.opcode)
            NOP: begin
                // Retires with nothing written
            end
            LDI_A, LDI_B, LDI_C: begin
                dec.reg_wr       = 1'b1;
                dec.flag_en      = 1'b1;
                dec.load_sets_zn = 1'b1;
                if (instr.opcode == LDI_B) begin
                    dec.dest = REG_B;
                end else if (instr.opcode == LDI_C) begin
                    dec.dest = REG_C;
                end
            end
            LDA: begin
                dec.mem_rd       = 1'b1;
                dec.reg_wr       = 1'b1;
                dec.flag_en      = 1'b1;
                dec.load_sets_zn = 1'b1;
            end
            PLA: begin
                dec.pull         = 1'b1;
                dec.reg_wr       = 1'b1;
                dec.flag_en      = 1'b1;
                dec.load_sets_zn = 1'b1;
            end
            // Stores leave registers and status alone
            STA: dec.mem_wr = 1'b1;
            PHA: dec.push   = 1'b1;
            ADD, SUB, AND_OP, OR_OP, XOR_OP, INR, DCR: begin
                dec.reg_wr  = 1'b1;
                dec.flag_en = 1'b1;
                case (instr.opcode)
                    ADD:     dec.alu_op = ALU_ADD;
                    SUB:     dec.alu_op = ALU_SUB;
                    AND_OP:  dec.alu_op = ALU_AND;
                    OR_OP:   dec.alu_op = ALU_OR;
                    XOR_OP:  dec.alu_op = ALU_XOR;
                    INR:     dec.alu_op = ALU_INR;
                    default: dec.alu_op = ALU_DCR;
                endcase
            end
            default: begin
                // Unknown opcode, all enables stay low
                dec.illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: rtl/pipe_pkg.sv
`include "cpu8_exec_cfg.svh"

package pipe_pkg;

    import arch_defs_pkg::*;

    // Raw instruction word as it arrives on the input stream
    typedef struct packed {
        opcode_t                    opcode;
        logic [`CPU8_DATA_WIDTH-1:0] operand;
    } instr_t;

    // Control record from decode, held in slot_dec
    typedef struct packed {
        opcode_t                    opcode;
        alu_op_t                    alu_op;
        reg_idx_t                   dest;
        logic                       reg_wr;
        logic                       mem_rd;
        logic                       mem_wr;
        logic                       push;
        logic                       pull;
        logic                       load_sets_zn;
        logic                       flag_en;
        logic                       illegal;
        logic [`CPU8_DATA_WIDTH-1:0] operand;
    } decoded_t;

    // Execute result, held in slot_exe until writeback
    typedef struct packed {
        opcode_t                    opcode;
        alu_op_t                    alu_op;
        reg_idx_t                   dest;
        logic                       reg_wr;
        logic [`CPU8_DATA_WIDTH-1:0] value;
        logic                       flag_en;
        logic                       load_sets_zn;
        logic                       alu_zero;
        logic                       alu_carry;
        logic                       alu_negative;
        logic                       illegal;
    } exec_result_t;

    // Record presented at the output for every instruction
    typedef struct packed {
        opcode_t                    opcode;
        reg_idx_t                   dest;
        logic                       reg_wr;
        logic [`CPU8_DATA_WIDTH-1:0] value;
        logic [`CPU8_DATA_WIDTH-1:0] status;
        logic                       illegal;
    } retire_t;

    // Committed register file and status, seen by execute
    typedef struct packed {
        logic [`CPU8_DATA_WIDTH-1:0] a;
        logic [`CPU8_DATA_WIDTH-1:0] b;
        logic [`CPU8_DATA_WIDTH-1:0] c;
        logic [`CPU8_DATA_WIDTH-1:0] status;
    } arch_state_t;

endpackage

// File: rtl/pipe_stage.sv
module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // Accept when empty or when the held entry leaves this cycle
    assign in_ready = !out_valid || out_ready;

    // Occupancy flag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Payload only moves on a transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

    // Held entry must not change while stalled downstream
    a_out_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
    );

endmodule

// File: rtl/status_logic_unit.sv
`include "cpu8_exec_cfg.svh"

module status_logic_unit
    import arch_defs_pkg::*;
(
    // Raw ALU flags
    input  logic                         alu_zero_in,
    input  logic                         alu_carry_in,
    input  logic                         alu_negative_in,
    // Load policy from decode
    input  logic                         load_sets_zn_in,
    input  opcode_t                      opcode_in,
    // Immediate for LDI
    input  logic [`CPU8_DATA_WIDTH-1:0]  temp_1_out_in,
    // Memory or stack byte for LDA and PLA
    input  logic [`CPU8_DATA_WIDTH-1:0]  internal_bus_in,
    input  logic [`CPU8_ALU_OP_W-1:0]    alu_op_in,
    // Committed status, source of the kept carry
    input  logic [`CPU8_DATA_WIDTH-1:0]  current_status_in,
    output logic                         zero_flag_out,
    output logic                         negative_flag_out,
    output logic                         carry_flag_out
);

    logic load_zero;
    logic load_negative;

    // Z and N of the loaded byte, picked by load type
    always_comb begin
        load_zero     = 1'b0;
        load_negative = 1'b0;
        if (load_sets_zn_in) begin
            case (opcode_in)
                LDI_A, LDI_B, LDI_C: begin
                    load_zero     = (temp_1_out_in == '0);
                    load_negative = temp_1_out_in[`CPU8_DATA_WIDTH-1];
                end
                LDA, PLA: begin
                    load_zero     = (internal_bus_in == '0);
                    load_negative = internal_bus_in[`CPU8_DATA_WIDTH-1];
                end
                default: begin
                    load_zero     = 1'b0;
                    load_negative = 1'b0;
                end
            endcase
        end
    end

    // ALU flags by default, loads and INR/DCR override
    always_comb begin
        zero_flag_out     = alu_zero_in;
        negative_flag_out = alu_negative_in;
        carry_flag_out    = alu_carry_in;
        if (load_sets_zn_in) begin
            zero_flag_out     = load_zero;
            negative_flag_out = load_negative;
            // Loads always clear C
            carry_flag_out    = 1'b0;
        end else if (alu_op_in == ALU_INR || alu_op_in == ALU_DCR) begin
            carry_flag_out = current_status_in[STATUS_CPU_CARRY];
        end
    end

endmodule

// File: rtl/writeback_unit.sv
`include "cpu8_exec_cfg.svh"

module writeback_unit
    import arch_defs_pkg::*;
    import pipe_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  exec_result_t res,
    input  logic         res_valid,
    output logic         res_ready,
    output arch_state_t  arch_state,
    output retire_t      retire,
    output logic         retire_valid,
    input  logic         retire_ready
);

    logic [`CPU8_DATA_WIDTH-1:0] status_next;
    logic                        z_flag;
    logic                        n_flag;
    logic                        c_flag;
    logic                        commit;

    status_logic_unit u_status (
        .alu_zero_in       (res.alu_zero),
        .alu_carry_in      (res.alu_carry),
        .alu_negative_in   (res.alu_negative),
        .load_sets_zn_in   (res.load_sets_zn),
        .opcode_in         (res.opcode),
        // Value already holds the immediate or the loaded byte
        .temp_1_out_in     (res.value),
        .internal_bus_in   (res.value),
        .alu_op_in         (res.alu_op),
        .current_status_in (arch_state.status),
        .zero_flag_out     (z_flag),
        .negative_flag_out (n_flag),
        .carry_flag_out    (c_flag)
    );

    // Retire register frees up when empty or drained this cycle
    assign res_ready = !retire_valid || retire_ready;
    assign commit    = res_valid && res_ready;

    // Status after this instruction, unchanged unless flag_en
    always_comb begin
        status_next = arch_state.status;
        if (res.flag_en) begin
            status_next[STATUS_CPU_ZERO]     = z_flag;
            status_next[STATUS_CPU_NEGATIVE] = n_flag;
            status_next[STATUS_CPU_CARRY]    = c_flag;
        end
    end

    // Architectural commit, same edge as the retire load
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arch_state <= '0;
        end else if (commit) begin
            if (res.reg_wr) begin
                case (res.dest)
                    REG_A:   arch_state.a <= res.value;
                    REG_B:   arch_state.b <= res.value;
                    default: arch_state.c <= res.value;
                endcase
            end
            arch_state.status <= status_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else if (res_ready) begin
            retire_valid <= res_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (commit) begin
            retire.opcode  <= res.opcode;
            retire.dest    <= res.dest;
            retire.reg_wr  <= res.reg_wr;
            retire.value   <= res.value;
            retire.status  <= status_next;
            retire.illegal <= res.illegal;
        end
    end

    // Illegal opcodes from decode must reach here with no register write
    a_illegal_no_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        (res_valid && res.illegal) |-> !res.reg_wr
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the cpu8_exec regression with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f cpu8_exec.f \
    --top-module tb_cpu8_exec \
    -Mdir obj_dir \
    -o sim_cpu8_exec

# tee keeps the pipeline status at zero, the log decides the result
./obj_dir/sim_cpu8_exec | tee sim.log

if grep -q "Regression failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

// File: test/tb_cpu8_exec.sv
`include "cpu8_exec_cfg.svh"

module tb_cpu8_exec
    import arch_defs_pkg::*;
    import pipe_pkg::*;
();

    localparam int DW         = `CPU8_DATA_WIDTH;
    localparam int CLK_PERIOD = 20;
    localparam int DRIVE_DLY  = 1;
    // Directed list, A/STA pairs over the LDA window, then random traffic
    localparam int N_DIRECTED = 49;
    localparam int N_PREFILL  = 32;
    localparam int N_RANDOM   = 300;
    localparam int N_TOTAL    = N_DIRECTED + N_PREFILL + N_RANDOM;

    logic    clk = 1'b0;
    logic    rst_n;
    logic    instr_valid;
    logic    instr_ready;
    instr_t  instr;
    logic    retire_valid;
    logic    retire_ready;
    retire_t retire;

    integer  seed = 32'h69f9a098;
    logic    bp_en;

    // Architectural state as the model sees it
    logic [DW-1:0] m_a;
    logic [DW-1:0] m_b;
    logic [DW-1:0] m_c;
    logic [DW-1:0] m_status;
    logic [DW-1:0] m_sp;
    logic [DW-1:0] m_mem [`CPU8_MEM_DEPTH];

    // Predicted records in issue order, with the test that issued each
    retire_t exp_q[$];
    string   name_q[$];
    int      n_issued = 0;
    int      n_retired = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cpu8_exec_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire       (retire)
    );

    // Z in bit 0, N in bit 1, C in bit 2, upper bits stay zero
    function automatic logic [DW-1:0] make_status(input logic [DW-1:0] v, input logic c);
        logic [DW-1:0] s;
        s                      = '0;
        s[STATUS_CPU_ZERO]     = (v == 8'h00);
        s[STATUS_CPU_NEGATIVE] = v[DW-1];
        s[STATUS_CPU_CARRY]    = c;
        return s;
    endfunction

    // Executes one instruction on the model and predicts its retire record
    function automatic retire_t ref_step(input instr_t ins);
        retire_t     r;
        logic        carry;
        logic        sets_flags;
        r          = '0;
        r.opcode   = ins.opcode;
        r.dest     = REG_A;
        r.value    = ins.operand;
        carry      = m_status[STATUS_CPU_CARRY];
        sets_flags = 1'b1;
        case (ins.opcode)
            LDI_A, LDI_B, LDI_C: begin
                r.reg_wr = 1'b1;
                carry    = 1'b0;
                if (ins.opcode == LDI_B) begin
                    r.dest = REG_B;
                end else if (ins.opcode == LDI_C) begin
                    r.dest = REG_C;
                end
            end
            LDA: begin
                r.value  = m_mem[ins.operand];
                r.reg_wr = 1'b1;
                carry    = 1'b0;
            end
            // Pre-increment, then read the top of the stack
            PLA: begin
                m_sp     = m_sp + 8'd1;
                r.value  = m_mem[m_sp];
                r.reg_wr = 1'b1;
                carry    = 1'b0;
            end
            STA: begin
                r.value              = m_a;
                m_mem[ins.operand]   = m_a;
                sets_flags           = 1'b0;
            end
            // Store at SP, then post-decrement
            PHA: begin
                r.value     = m_a;
                m_mem[m_sp] = m_a;
                m_sp        = m_sp - 8'd1;
                sets_flags  = 1'b0;
            end
            // Carry out when the 8-bit sum wraps below A
            ADD: begin
                r.value  = m_a + m_b;
                carry    = (r.value < m_a);
                r.reg_wr = 1'b1;
            end
            // Borrow when B exceeds A
            SUB: begin
                r.value  = m_a - m_b;
                carry    = (m_a < m_b);
                r.reg_wr = 1'b1;
            end
            AND_OP, OR_OP, XOR_OP: begin
                if (ins.opcode == AND_OP) begin
                    r.value = m_a & m_b;
                end else if (ins.opcode == OR_OP) begin
                    r.value = m_a | m_b;
                end else begin
                    r.value = m_a ^ m_b;
                end
                carry    = 1'b0;
                r.reg_wr = 1'b1;
            end
            // Increment and decrement leave C as it was
            INR: begin
                r.value  = m_a + 8'd1;
                r.reg_wr = 1'b1;
            end
            DCR: begin
                r.value  = m_a - 8'd1;
                r.reg_wr = 1'b1;
            end
            NOP: sets_flags = 1'b0;
            default: begin
                r.illegal  = 1'b1;
                sets_flags = 1'b0;
            end
        endcase
        if (sets_flags) begin
            m_status = make_status(r.value, carry);
        end
        r.status = m_status;
        if (r.reg_wr) begin
            case (r.dest)
                REG_A:   m_a = r.value;
                REG_B:   m_b = r.value;
                default: m_c = r.value;
            endcase
        end
        return r;
    endfunction

    // Random word, kept legal for the model: LDA/STA in 0..15, bounded stack
    function automatic logic [15:0] rand_instr();
        logic [31:0] r_op;
        logic [31:0] r_data;
        logic [7:0]  op;
        logic [7:0]  opnd;
        r_op   = $random(seed);
        r_data = $random(seed);
        opnd   = r_data[7:0];
        case (r_op % 18)
            0:       op = LDI_A;
            1:       op = LDI_B;
            2:       op = LDI_C;
            3:       op = LDA;
            4:       op = STA;
            5:       op = PHA;
            6:       op = PLA;
            7:       op = ADD;
            8:       op = SUB;
            9:       op = AND_OP;
            10:      op = OR_OP;
            11:      op = XOR_OP;
            12:      op = INR;
            13:      op = DCR;
            14:      op = NOP;
            15:      op = ADD;
            16:      op = 8'h05;
            default: op = 8'hC7;
        endcase
        if (op == LDA || op == STA) begin
            opnd = opnd & 8'h0F;
        end
        if (op == PLA && m_sp == `CPU8_SP_RESET) begin
            op = PHA;
        end else if (op == PHA && m_sp < 8'hC0) begin
            op = PLA;
        end
        return {op, opnd};
    endfunction

    task automatic check_value(input string name, input logic [15:0] exp_v,
                               input logic [15:0] act_v);
        if (exp_v !== act_v) begin
            $display("FAIL %s expected %0h actual %0h", name, exp_v, act_v);
            $display("Regression failed");
            $fatal(1, "retire record mismatch");
        end
    endtask

    // Predict, hold valid until the DUT takes the word, return just after the edge
    task automatic issue(input logic [15:0] word, input string name);
        instr_t ins;
        ins = word;
        exp_q.push_back(ref_step(ins));
        name_q.push_back(name);
        instr       = ins;
        instr_valid = 1'b1;
        @(negedge clk);
        while (!instr_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DLY;
        n_issued++;
    endtask

    // Output back-pressure, low about a quarter of the cycles when enabled
    initial begin : drive_retire_ready
        logic [31:0] rnd;
        logic        ready_next;
        retire_ready = 1'b1;
        forever begin
            @(posedge clk);
            // Drawn on the edge, apart from the draws of the main process
            rnd        = $random(seed);
            ready_next = bp_en ? (rnd[1:0] != 2'b00) : 1'b1;
            #DRIVE_DLY;
            retire_ready = ready_next;
        end
    end

    // Retire transfer is decided at the next edge, fields are stable here
    always @(negedge clk) begin : compare_retire
        retire_t exp_r;
        string   nm;
        if (rst_n && retire_valid && retire_ready) begin
            if (exp_q.size() == 0) begin
                $display("DUT retired a record with no instruction outstanding");
                $display("Regression failed");
                $fatal(1, "extra retire record");
            end else begin
                exp_r = exp_q.pop_front();
                nm    = name_q.pop_front();
                check_value({nm, ".opcode"}, 16'(exp_r.opcode), 16'(retire.opcode));
                check_value({nm, ".dest"}, 16'(exp_r.dest), 16'(retire.dest));
                check_value({nm, ".reg_wr"}, 16'(exp_r.reg_wr), 16'(retire.reg_wr));
                check_value({nm, ".illegal"}, 16'(exp_r.illegal), 16'(retire.illegal));
                check_value({nm, ".status"}, 16'(exp_r.status), 16'(retire.status));
                // Value matters for register writes and for the byte a store puts out
                if (exp_r.reg_wr || exp_r.opcode == STA || exp_r.opcode == PHA) begin
                    check_value({nm, ".value"}, 16'(exp_r.value), 16'(retire.value));
                end
                n_retired++;
            end
        end
    end

    // Run limit from the instruction count, reset included in the margin
    initial begin : watchdog
        #((N_TOTAL * 40 + 200) * CLK_PERIOD);
        $display("Timeout: DUT stopped retiring before all instructions completed");
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        logic [31:0] rnd;
        int          i;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        bp_en       = 1'b0;
        m_a         = '0;
        m_b         = '0;
        m_c         = '0;
        m_status    = '0;
        m_sp        = `CPU8_SP_RESET;
        repeat (4) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        // Loads
        issue({LDI_A, 8'h00}, "ldi_zero");
        issue({LDI_A, 8'h80}, "ldi_negative");
        issue({LDI_B, 8'h35}, "ldi_positive");
        issue({LDI_C, 8'h7F}, "ldi_c");
        // ADD carry out, INR keeps it
        issue({LDI_A, 8'hF0}, "add_setup");
        issue({LDI_B, 8'h20}, "add_setup");
        issue({ADD, 8'h00}, "add_carry");
        issue({INR, 8'h00}, "inr_keeps_c");
        issue({LDI_A, 8'hFF}, "inr_setup");
        issue({INR, 8'h00}, "inr_wrap");
        issue({DCR, 8'h00}, "dcr_wrap");
        issue({LDI_B, 8'h01}, "sub_setup");
        issue({SUB, 8'h00}, "sub_no_borrow");
        issue({LDI_A, 8'h00}, "sub_setup");
        issue({SUB, 8'h00}, "sub_borrow");
        // C is set here, FF and 00 edges must keep it
        issue({INR, 8'h00}, "inr_ff_keeps_c");
        issue({DCR, 8'h00}, "dcr_zero_keeps_c");
        issue({LDI_B, 8'h0F}, "logic_setup");
        issue({AND_OP, 8'h00}, "and_op");
        issue({OR_OP, 8'h00}, "or_op");
        issue({XOR_OP, 8'h00}, "xor_zero");
        // Memory round trip, Z set by B so a flag write from A would show
        issue({LDI_A, 8'h5A}, "mem_setup");
        issue({LDI_B, 8'h00}, "mem_setup");
        issue({STA, 8'h10}, "sta_keeps_status");
        issue({LDI_A, 8'h00}, "mem_setup");
        issue({LDA, 8'h10}, "lda_readback");
        // Stack, three deep, N set by C ahead of the first push
        issue({LDI_A, 8'h11}, "stack_setup");
        issue({LDI_C, 8'h80}, "stack_setup");
        issue({PHA, 8'h00}, "pha_keeps_status");
        issue({LDI_A, 8'h22}, "stack_setup");
        issue({PHA, 8'h00}, "pha_keeps_status");
        issue({LDI_A, 8'h33}, "stack_setup");
        issue({PHA, 8'h00}, "pha_keeps_status");
        issue({PLA, 8'h00}, "pla_lifo");
        issue({PLA, 8'h00}, "pla_lifo");
        issue({PLA, 8'h00}, "pla_lifo");
        // Each one depends on the one before
        issue({LDI_A, 8'h40}, "fwd_chain");
        issue({LDI_B, 8'h41}, "fwd_chain");
        issue({ADD, 8'h00}, "fwd_chain");
        issue({STA, 8'h20}, "fwd_chain");
        issue({LDA, 8'h20}, "fwd_chain");
        issue({ADD, 8'h00}, "fwd_chain");
        issue({PHA, 8'h00}, "fwd_chain");
        issue({PLA, 8'h00}, "fwd_chain");
        issue({INR, 8'h00}, "fwd_chain");
        // Unknown opcodes and NOP
        issue({8'h05, 8'hAA}, "illegal");
        issue({8'hFF, 8'h00}, "illegal");
        issue({8'h50, 8'h12}, "illegal");
        issue({NOP, 8'h00}, "nop");

        // Random stalls from here on
        bp_en = 1'b1;
        for (i = 0; i < N_PREFILL / 2; i++) begin
            rnd = $random(seed);
            issue({LDI_A, rnd[7:0]}, "prefill");
            issue({STA, 8'(i)}, "prefill");
        end
        for (i = 0; i < N_RANDOM; i++) begin
            issue(rand_instr(), "random");
        end
        instr_valid = 1'b0;

        wait (n_retired == n_issued);
        // Extra cycles catch a duplicated record
        repeat (10) @(posedge clk);
        if (exp_q.size() != 0 || n_issued != N_TOTAL) begin
            $display("Run ended with %0d records missing", exp_q.size());
            $display("Regression failed");
            $fatal(1, "incomplete run");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule
